//--- filelist.f
+incdir+verilog
verilog/bus_arb_pkg.sv
verilog/op_classifier.sv
verilog/order_fifo.sv
verilog/bus_router.sv
verilog/lane_bus_arbiter.sv
sim/lane_bus_arbiter_sva.sv
sim/tb_lane_bus_arbiter.sv

//--- run.sh
#!/bin/sh
# Builds the lane bus arbiter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_lane_bus_arbiter \
  --Mdir obj_dir -o tb_lane_bus_arbiter \
  -f filelist.f \
  && ./obj_dir/tb_lane_bus_arbiter > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qF '*** PASSED ***' sim.log 2>/dev/null && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim/tb_lane_bus_arbiter.sv
// Random-stimulus testbench of the lane bus arbiter, checked every cycle against a reference model

`include "bus_arb_settings.svh"

module tb_lane_bus_arbiter;

  localparam int          RESET_CYCLES = 2;
  localparam int          IDLE_CYCLES  = 50;
  localparam int          TEST_CYCLES  = 2000;
  localparam int unsigned MAX_CYCLES   = 3000;
  localparam int          DEPTH        = `BUS_ARB_ORDER_DEPTH;
  localparam logic [31:0] SEED         = 32'h393b2fc2;

  logic                         clk_i;
  logic                         rst_n_i;
  logic                         vfu_op_valid_i;
  bus_arb_pkg::op_e             vfu_op_i;
  logic                         flush_i;
  bus_arb_pkg::operand_stream_t opq_operand_i;
  logic                         opq_cmd_pop_i;
  logic                         opq_ready_o;
  bus_arb_pkg::operand_stream_t alu_red_i;
  logic                         alu_red_complete_i;
  logic                         alu_red_gnt_o;
  bus_arb_pkg::operand_stream_t fpu_red_i;
  logic                         fpu_red_complete_i;
  logic                         fpu_red_gnt_o;
  bus_arb_pkg::operand_stream_t sldu_operand_o;
  logic                         sldu_operand_ready_i;
  logic                         sldu_red_valid_i;
  logic                         sldu_result_gnt_o;
  logic                         addrgen_operand_valid_o;
  logic                         addrgen_operand_ready_i;
  logic                         opq_result_gnt_i;
  logic                         alu_red_ready_i;
  logic                         fpu_red_ready_i;
  logic                         alu_red_valid_o;
  logic                         fpu_red_valid_o;

  // Reference model state
  logic                  model_reg_valid;
  bus_arb_pkg::op_e      model_reg_op;
  bus_arb_pkg::bus_src_e model_order [$];

  logic [31:0] rng_state;
  logic        checks_on;
  int unsigned cycle_count = 0;

  lane_bus_arbiter u_dut (
    .clk_i                   (clk_i),
    .rst_n_i                 (rst_n_i),
    .vfu_op_valid_i          (vfu_op_valid_i),
    .vfu_op_i                (vfu_op_i),
    .flush_i                 (flush_i),
    .opq_operand_i           (opq_operand_i),
    .opq_cmd_pop_i           (opq_cmd_pop_i),
    .opq_ready_o             (opq_ready_o),
    .alu_red_i               (alu_red_i),
    .alu_red_complete_i      (alu_red_complete_i),
    .alu_red_gnt_o           (alu_red_gnt_o),
    .fpu_red_i               (fpu_red_i),
    .fpu_red_complete_i      (fpu_red_complete_i),
    .fpu_red_gnt_o           (fpu_red_gnt_o),
    .sldu_operand_o          (sldu_operand_o),
    .sldu_operand_ready_i    (sldu_operand_ready_i),
    .sldu_red_valid_i        (sldu_red_valid_i),
    .sldu_result_gnt_o       (sldu_result_gnt_o),
    .addrgen_operand_valid_o (addrgen_operand_valid_o),
    .addrgen_operand_ready_i (addrgen_operand_ready_i),
    .opq_result_gnt_i        (opq_result_gnt_i),
    .alu_red_ready_i         (alu_red_ready_i),
    .fpu_red_ready_i         (fpu_red_ready_i),
    .alu_red_valid_o         (alu_red_valid_o),
    .fpu_red_valid_o         (fpu_red_valid_o)
  );

  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Random numbers and opcode helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic bus_arb_pkg::op_e op_from_index(input logic [3:0] idx);
    bus_arb_pkg::op_e op;
    case (idx)
      4'd0:    op = bus_arb_pkg::VADD;
      4'd1:    op = bus_arb_pkg::VSLIDEUP;
      4'd2:    op = bus_arb_pkg::VSLIDEDOWN;
      4'd3:    op = bus_arb_pkg::VLXE;
      4'd4:    op = bus_arb_pkg::VSXE;
      4'd5:    op = bus_arb_pkg::VREDSUM;
      4'd6:    op = bus_arb_pkg::VREDAND;
      4'd7:    op = bus_arb_pkg::VREDOR;
      4'd8:    op = bus_arb_pkg::VREDXOR;
      4'd9:    op = bus_arb_pkg::VWREDSUM;
      4'd10:   op = bus_arb_pkg::VFREDUSUM;
      4'd11:   op = bus_arb_pkg::VFREDOSUM;
      4'd12:   op = bus_arb_pkg::VFWREDUSUM;
      4'd13:   op = bus_arb_pkg::VFWREDOSUM;
      default: op = bus_arb_pkg::VMUL;
    endcase
    return op;
  endfunction

  // Bit 2 flags a bus user, bits 1:0 carry its class
  function automatic logic [2:0] class_of(input bus_arb_pkg::op_e op);
    logic [2:0] cls;
    cls = 3'b000;
    if (op == bus_arb_pkg::VSLIDEUP || op == bus_arb_pkg::VSLIDEDOWN) begin
      cls = {1'b1, bus_arb_pkg::SRC_SLDU};
    end else if (op == bus_arb_pkg::VLXE || op == bus_arb_pkg::VSXE) begin
      cls = {1'b1, bus_arb_pkg::SRC_ADDRGEN};
    end else if (op >= bus_arb_pkg::VREDSUM && op <= bus_arb_pkg::VWREDSUM) begin
      cls = {1'b1, bus_arb_pkg::SRC_ALU_RED};
    end else if (op >= bus_arb_pkg::VFREDUSUM && op <= bus_arb_pkg::VFWREDOSUM) begin
      cls = {1'b1, bus_arb_pkg::SRC_FPU_RED};
    end
    return cls;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // One rising edge of the model, using the inputs held during the ending cycle
  task automatic advance_model();
    logic [2:0]            cls;
    logic                  done;
    bus_arb_pkg::bus_src_e head;
    cls = class_of(model_reg_op);
    if (flush_i) begin
      model_order.delete();
    end else begin
      if (model_order.size() != 0) begin
        head = model_order[0];
        if (head == bus_arb_pkg::SRC_ALU_RED) begin
          done = alu_red_complete_i;
        end else if (head == bus_arb_pkg::SRC_FPU_RED) begin
          done = fpu_red_complete_i;
        end else begin
          done = opq_cmd_pop_i;
        end
        if (done) begin
          void'(model_order.pop_front());
        end
      end
      if (model_reg_valid && cls[2]) begin
        model_order.push_back(bus_arb_pkg::bus_src_e'(cls[1:0]));
      end
    end
    model_reg_valid = vfu_op_valid_i;
    model_reg_op    = vfu_op_i;
  endtask

  task automatic drive_inputs(input logic ops_on);
    logic [31:0] r;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [2:0]  cls;
    int          pending;
    r   = rand_word();
    cls = class_of(model_reg_op);
    // Outstanding entries include the op still sitting in the register
    pending = model_order.size();
    if (model_reg_valid && cls[2]) begin
      pending = pending + 1;
    end
    vfu_op_valid_i          <= ops_on && r[1] && (pending < DEPTH);
    vfu_op_i                <= op_from_index(r[5:2]);
    flush_i                 <= ops_on && (r[11:6] == 6'd0);
    opq_cmd_pop_i           <= r[12] & r[13];
    alu_red_complete_i      <= r[14] & r[15];
    fpu_red_complete_i      <= r[16] & r[17];
    sldu_operand_ready_i    <= r[18];
    addrgen_operand_ready_i <= r[19];
    sldu_red_valid_i        <= r[20];
    opq_result_gnt_i        <= r[21];
    alu_red_ready_i         <= r[22];
    fpu_red_ready_i         <= r[23];
    opq_operand_i.valid     <= r[24];
    alu_red_i.valid         <= r[25];
    fpu_red_i.valid         <= r[26];
    d0 = rand_word();
    d1 = rand_word();
    opq_operand_i.data <= {d0, d1};
    d0 = rand_word();
    d1 = rand_word();
    alu_red_i.data <= {d1, d0};
    d0 = rand_word();
    d1 = rand_word();
    fpu_red_i.data <= {d0, ~d1};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [64:0] actual,
                             input logic [64:0] expected);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    bus_arb_pkg::operand_stream_t exp_bus;
    bus_arb_pkg::bus_src_e        head;
    logic exp_ag_valid;
    logic exp_opq_ready;
    logic exp_alu_gnt;
    logic exp_fpu_gnt;
    logic exp_alu_valid;
    logic exp_fpu_valid;
    logic exp_res_gnt;
    exp_bus       = '0;
    exp_ag_valid  = 1'b0;
    exp_opq_ready = 1'b0;
    exp_alu_gnt   = 1'b0;
    exp_fpu_gnt   = 1'b0;
    exp_alu_valid = 1'b0;
    exp_fpu_valid = 1'b0;
    exp_res_gnt   = 1'b0;
    // Nothing is routed while the order is empty
    if (model_order.size() != 0) begin
      head = model_order[0];
      if (head == bus_arb_pkg::SRC_SLDU) begin
        exp_bus       = opq_operand_i;
        exp_opq_ready = sldu_operand_ready_i;
        exp_res_gnt   = opq_result_gnt_i;
      end else if (head == bus_arb_pkg::SRC_ADDRGEN) begin
        exp_bus.data  = opq_operand_i.data;
        exp_ag_valid  = opq_operand_i.valid;
        exp_opq_ready = addrgen_operand_ready_i;
      end else if (head == bus_arb_pkg::SRC_ALU_RED) begin
        exp_bus       = alu_red_i;
        exp_alu_gnt   = sldu_operand_ready_i;
        exp_alu_valid = sldu_red_valid_i;
        exp_res_gnt   = alu_red_ready_i;
      end else begin
        exp_bus       = fpu_red_i;
        exp_fpu_gnt   = sldu_operand_ready_i;
        exp_fpu_valid = sldu_red_valid_i;
        exp_res_gnt   = fpu_red_ready_i;
      end
    end
    check_value("sldu_operand_o", sldu_operand_o, exp_bus);
    check_value("addrgen_operand_valid_o", 65'(addrgen_operand_valid_o), 65'(exp_ag_valid));
    check_value("opq_ready_o", 65'(opq_ready_o), 65'(exp_opq_ready));
    check_value("alu_red_gnt_o", 65'(alu_red_gnt_o), 65'(exp_alu_gnt));
    check_value("fpu_red_gnt_o", 65'(fpu_red_gnt_o), 65'(exp_fpu_gnt));
    check_value("alu_red_valid_o", 65'(alu_red_valid_o), 65'(exp_alu_valid));
    check_value("fpu_red_valid_o", 65'(fpu_red_valid_o), 65'(exp_fpu_valid));
    check_value("sldu_result_gnt_o", 65'(sldu_result_gnt_o), 65'(exp_res_gnt));
  endtask

  // Outputs are settled half a cycle after the inputs change
  always @(negedge clk_i) begin
    if (checks_on) begin
      check_outputs();
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rng_state               = SEED;
    checks_on               = 1'b0;
    model_reg_valid         = 1'b0;
    model_reg_op            = bus_arb_pkg::VADD;
    clk_i                   = 1'b0;
    rst_n_i                 = 1'b0;
    vfu_op_valid_i          = 1'b0;
    vfu_op_i                = bus_arb_pkg::VADD;
    flush_i                 = 1'b0;
    opq_operand_i           = '0;
    opq_cmd_pop_i           = 1'b0;
    alu_red_i               = '0;
    alu_red_complete_i      = 1'b0;
    fpu_red_i               = '0;
    fpu_red_complete_i      = 1'b0;
    sldu_operand_ready_i    = 1'b0;
    sldu_red_valid_i        = 1'b0;
    addrgen_operand_ready_i = 1'b0;
    opq_result_gnt_i        = 1'b0;
    alu_red_ready_i         = 1'b0;
    fpu_red_ready_i         = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i   <= 1'b1;
    checks_on = 1'b1;
    // Inputs toggle with no operations issued
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(posedge clk_i);
      advance_model();
      drive_inputs(1'b0);
    end
    // Mixed operations, completions and flushes
    for (int i = 0; i < TEST_CYCLES; i++) begin
      @(posedge clk_i);
      advance_model();
      drive_inputs(1'b1);
    end
    @(posedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- sim/lane_bus_arbiter_sva.sv
// Concurrent checks on bus routing exclusivity and order FIFO occupancy, bound into the arbiter top

`include "bus_arb_settings.svh"

module lane_bus_arbiter_sva (
  input logic clk_i,
  input logic rst_n_i,
  input logic flush_i,
  input logic push_i,
  input logic pop_i,
  input logic empty_i,
  input logic sldu_valid_i,
  input logic addrgen_valid_i,
  input logic alu_red_valid_i,
  input logic fpu_red_valid_i,
  input logic any_grant_i
);

  localparam int DEPTH = `BUS_ARB_ORDER_DEPTH;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  // Occupancy of the order FIFO as seen from its push and pop
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (flush_i) begin
      count_q <= '0;
    end else if (push_i && !pop_i && int'(count_q) < DEPTH) begin
      count_q <= count_q + 1'b1;
    end else if (pop_i && !push_i && count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Routing
  //////////////////////////////////////////////////////////////////////

  bus_valid_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(sldu_valid_i && addrgen_valid_i))
    else $error("Slide unit and address generator valids both high");

  idle_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    empty_i |-> !(sldu_valid_i || addrgen_valid_i || alu_red_valid_i ||
                  fpu_red_valid_i || any_grant_i))
    else $error("Routed valid or grant high with an empty order FIFO");

  red_valid_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(alu_red_valid_i && fpu_red_valid_i))
    else $error("Reduction valid sent to both ALU and FPU");

  //////////////////////////////////////////////////////////////////////
  // Order FIFO bounds
  //////////////////////////////////////////////////////////////////////

  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(push_i && !pop_i && !flush_i && int'(count_q) == DEPTH))
    else $error("Push into a full order FIFO");

  empty_matches_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    empty_i == (count_q == '0))
    else $error("Order FIFO empty flag disagrees with its occupancy");

endmodule

bind lane_bus_arbiter lane_bus_arbiter_sva u_sva (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .flush_i         (flush_i),
  .push_i          (push),
  .pop_i           (pop),
  .empty_i         (empty),
  .sldu_valid_i    (sldu_operand_o.valid),
  .addrgen_valid_i (addrgen_operand_valid_o),
  .alu_red_valid_i (alu_red_valid_o),
  .fpu_red_valid_i (fpu_red_valid_o),
  .any_grant_i     (alu_red_gnt_o || fpu_red_gnt_o || sldu_result_gnt_o || opq_ready_o)
);

//--- verilog/lane_bus_arbiter.sv
// Top level of the lane's shared operand bus arbiter, chaining classifier, order FIFO and router

module lane_bus_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Sequencer
  input  logic                         vfu_op_valid_i,
  input  bus_arb_pkg::op_e             vfu_op_i,
  // Store exception
  input  logic                         flush_i,
  // Operand queue
  input  bus_arb_pkg::operand_stream_t opq_operand_i,
  input  logic                         opq_cmd_pop_i,
  output logic                         opq_ready_o,
  // ALU reduction
  input  bus_arb_pkg::operand_stream_t alu_red_i,
  input  logic                         alu_red_complete_i,
  output logic                         alu_red_gnt_o,
  // FPU reduction
  input  bus_arb_pkg::operand_stream_t fpu_red_i,
  input  logic                         fpu_red_complete_i,
  output logic                         fpu_red_gnt_o,
  // Slide unit
  output bus_arb_pkg::operand_stream_t sldu_operand_o,
  input  logic                         sldu_operand_ready_i,
  input  logic                         sldu_red_valid_i,
  output logic                         sldu_result_gnt_o,
  // Address generator
  output logic                         addrgen_operand_valid_o,
  input  logic                         addrgen_operand_ready_i,
  // Result grant candidates
  input  logic                         opq_result_gnt_i,
  input  logic                         alu_red_ready_i,
  input  logic                         fpu_red_ready_i,
  // Reduction valid towards the functional units
  output logic                         alu_red_valid_o,
  output logic                         fpu_red_valid_o
);

  logic                  push;
  bus_arb_pkg::bus_src_e push_src;
  bus_arb_pkg::bus_src_e head_src;
  logic                  empty;
  logic                  pop;

  //////////////////////////////////////////////////////////////////////
  // Classify, record order, route
  //////////////////////////////////////////////////////////////////////

  op_classifier u_classifier (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .vfu_op_valid_i (vfu_op_valid_i),
    .vfu_op_i       (vfu_op_i),
    .push_o         (push),
    .push_src_o     (push_src)
  );

  order_fifo u_order_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .push_i     (push),
    .push_src_i (push_src),
    .pop_i      (pop),
    .head_src_o (head_src),
    .empty_o    (empty)
  );

  bus_router u_router (
    .head_src_i              (head_src),
    .empty_i                 (empty),
    .opq_operand_i           (opq_operand_i),
    .alu_red_i               (alu_red_i),
    .fpu_red_i               (fpu_red_i),
    .opq_cmd_pop_i           (opq_cmd_pop_i),
    .alu_red_complete_i      (alu_red_complete_i),
    .fpu_red_complete_i      (fpu_red_complete_i),
    .sldu_operand_ready_i    (sldu_operand_ready_i),
    .addrgen_operand_ready_i (addrgen_operand_ready_i),
    .sldu_red_valid_i        (sldu_red_valid_i),
    .opq_result_gnt_i        (opq_result_gnt_i),
    .alu_red_ready_i         (alu_red_ready_i),
    .fpu_red_ready_i         (fpu_red_ready_i),
    .sldu_operand_o          (sldu_operand_o),
    .addrgen_operand_valid_o (addrgen_operand_valid_o),
    .opq_ready_o             (opq_ready_o),
    .alu_red_gnt_o           (alu_red_gnt_o),
    .fpu_red_gnt_o           (fpu_red_gnt_o),
    .alu_red_valid_o         (alu_red_valid_o),
    .fpu_red_valid_o         (fpu_red_valid_o),
    .sldu_result_gnt_o       (sldu_result_gnt_o),
    .pop_o                   (pop)
  );

endmodule

//--- verilog/bus_router.sv
// Steers the shared operand bus and its handshakes by the class at the head of the order FIFO

module bus_router (
  input  bus_arb_pkg::bus_src_e        head_src_i,
  input  logic                         empty_i,
  // Bus sources
  input  bus_arb_pkg::operand_stream_t opq_operand_i,
  input  bus_arb_pkg::operand_stream_t alu_red_i,
  input  bus_arb_pkg::operand_stream_t fpu_red_i,
  // Completion strobes
  input  logic                         opq_cmd_pop_i,
  input  logic                         alu_red_complete_i,
  input  logic                         fpu_red_complete_i,
  // Receiver readies
  input  logic                         sldu_operand_ready_i,
  input  logic                         addrgen_operand_ready_i,
  // Slide unit reduction path
  input  logic                         sldu_red_valid_i,
  input  logic                         opq_result_gnt_i,
  input  logic                         alu_red_ready_i,
  input  logic                         fpu_red_ready_i,
  // Routed outputs
  output bus_arb_pkg::operand_stream_t sldu_operand_o,
  output logic                         addrgen_operand_valid_o,
  output logic                         opq_ready_o,
  output logic                         alu_red_gnt_o,
  output logic                         fpu_red_gnt_o,
  output logic                         alu_red_valid_o,
  output logic                         fpu_red_valid_o,
  output logic                         sldu_result_gnt_o,
  output logic                         pop_o
);

  // One-hot view of the head, all low while nothing is pending
  logic head_sldu;
  logic head_addrgen;
  logic head_alu;
  logic head_fpu;

  assign head_sldu    = !empty_i && (head_src_i == bus_arb_pkg::SRC_SLDU);
  assign head_addrgen = !empty_i && (head_src_i == bus_arb_pkg::SRC_ADDRGEN);
  assign head_alu     = !empty_i && (head_src_i == bus_arb_pkg::SRC_ALU_RED);
  assign head_fpu     = !empty_i && (head_src_i == bus_arb_pkg::SRC_FPU_RED);

  //////////////////////////////////////////////////////////////////////
  // Three-way data mux onto the shared bus
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sldu_operand_o = '0;
    if (head_alu) begin
      sldu_operand_o = alu_red_i;
    end else if (head_fpu) begin
      sldu_operand_o = fpu_red_i;
    end else if (head_sldu || head_addrgen) begin
      sldu_operand_o.data = opq_operand_i.data;
      // Operand queue valid only reaches the slide unit on its own turn
      sldu_operand_o.valid = head_sldu && opq_operand_i.valid;
    end
  end

  // Address generator shares the bus data but has its own valid
  assign addrgen_operand_valid_o = head_addrgen && opq_operand_i.valid;

  //////////////////////////////////////////////////////////////////////
  // Ready back to the selected source
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    opq_ready_o = 1'b0;
    if (head_sldu) begin
      opq_ready_o = sldu_operand_ready_i;
    end else if (head_addrgen) begin
      opq_ready_o = addrgen_operand_ready_i;
    end
  end

  // During a reduction the slide unit drains the functional unit
  assign alu_red_gnt_o = head_alu && sldu_operand_ready_i;
  assign fpu_red_gnt_o = head_fpu && sldu_operand_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Slide unit reduction fan-out and result grant
  //////////////////////////////////////////////////////////////////////

  assign alu_red_valid_o = head_alu && sldu_red_valid_i;
  assign fpu_red_valid_o = head_fpu && sldu_red_valid_i;

  always_comb begin
    sldu_result_gnt_o = 1'b0;
    if (head_sldu) begin
      sldu_result_gnt_o = opq_result_gnt_i;
    end else if (head_alu) begin
      sldu_result_gnt_o = alu_red_ready_i;
    end else if (head_fpu) begin
      sldu_result_gnt_o = fpu_red_ready_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Release of the head
  //////////////////////////////////////////////////////////////////////

  // Each class ends on its own completion strobe
  always_comb begin
    pop_o = 1'b0;
    if (head_sldu || head_addrgen) begin
      pop_o = opq_cmd_pop_i;
    end else if (head_alu) begin
      pop_o = alu_red_complete_i;
    end else if (head_fpu) begin
      pop_o = fpu_red_complete_i;
    end
  end

endmodule

//--- verilog/order_fifo.sv
// Flushable FIFO of bus source classes that keeps the shared bus in instruction order

`include "bus_arb_settings.svh"

module order_fifo #(
  parameter int unsigned DEPTH = `BUS_ARB_ORDER_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  bus_arb_pkg::bus_src_e push_src_i,
  input  logic                  pop_i,
  output bus_arb_pkg::bus_src_e head_src_o,
  output logic                  empty_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  // Storage of the pending classes
  bus_arb_pkg::bus_src_e mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  logic full;
  logic do_push;
  logic do_pop;

  //////////////////////////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////////////////////////

  assign empty_o = (count_q == '0);
  assign full    = (count_q == DEPTH[PTR_W:0]);

  // A full FIFO still takes a push when the head leaves in the same cycle
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full || do_pop);

  assign head_src_o = mem_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Store exception drops every pending entry and any new one
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= push_src_i;
    end
  end

endmodule

//--- verilog/op_classifier.sv
// Registers each issued operation and turns bus users into a push of their bus source class

module op_classifier (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  vfu_op_valid_i,
  input  bus_arb_pkg::op_e      vfu_op_i,
  output logic                  push_o,
  output bus_arb_pkg::bus_src_e push_src_o
);

  logic             op_valid_q;
  bus_arb_pkg::op_e op_q;

  //////////////////////////////////////////////////////////////////////
  // Timing cut
  //////////////////////////////////////////////////////////////////////

  // The sequencer strobe and opcode come from far away
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_valid_q <= 1'b0;
      op_q       <= bus_arb_pkg::VADD;
    end else begin
      op_valid_q <= vfu_op_valid_i;
      op_q       <= vfu_op_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    push_o     = 1'b0;
    push_src_o = bus_arb_pkg::SRC_SLDU;
    if (op_valid_q) begin
      case (op_q) inside
        bus_arb_pkg::VSLIDEUP, bus_arb_pkg::VSLIDEDOWN: begin
          push_o     = 1'b1;
          push_src_o = bus_arb_pkg::SRC_SLDU;
        end
        bus_arb_pkg::VLXE, bus_arb_pkg::VSXE: begin
          push_o     = 1'b1;
          push_src_o = bus_arb_pkg::SRC_ADDRGEN;
        end
        [bus_arb_pkg::VREDSUM : bus_arb_pkg::VWREDSUM]: begin
          push_o     = 1'b1;
          push_src_o = bus_arb_pkg::SRC_ALU_RED;
        end
        [bus_arb_pkg::VFREDUSUM : bus_arb_pkg::VFWREDOSUM]: begin
          push_o     = 1'b1;
          push_src_o = bus_arb_pkg::SRC_FPU_RED;
        end
        // Not a user of the shared bus
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/bus_arb_pkg.sv
// Shared types of the lane bus arbiter, reached by scoped names from every file

`include "bus_arb_settings.svh"

package bus_arb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Operation codes
  //////////////////////////////////////////////////////////////////////

  // Reduction codes are kept contiguous so that ranges decode them
  typedef enum logic [`BUS_ARB_OP_WIDTH-1:0] {
    VADD       = 6'd0,
    VMUL       = 6'd1,
    VSLIDEUP   = 6'd2,
    VSLIDEDOWN = 6'd3,
    VLXE       = 6'd4,
    VSXE       = 6'd5,
    // Integer reductions
    VREDSUM    = 6'd8,
    VREDAND    = 6'd9,
    VREDOR     = 6'd10,
    VREDXOR    = 6'd11,
    VWREDSUM   = 6'd12,
    // Floating-point reductions
    VFREDUSUM  = 6'd16,
    VFREDOSUM  = 6'd17,
    VFWREDUSUM = 6'd18,
    VFWREDOSUM = 6'd19
  } op_e;

  //////////////////////////////////////////////////////////////////////
  // Bus ownership
  //////////////////////////////////////////////////////////////////////

  // Which class of instruction currently owns the shared operand bus
  typedef enum logic [1:0] {
    SRC_SLDU    = 2'd0,
    SRC_ADDRGEN = 2'd1,
    SRC_ALU_RED = 2'd2,
    SRC_FPU_RED = 2'd3
  } bus_src_e;

  // One operand beat with its valid
  typedef struct packed {
    logic                     valid;
    logic [`BUS_ARB_ELEN-1:0] data;
  } operand_stream_t;

endpackage

//--- verilog/bus_arb_settings.svh
// Sizing macros for the lane bus arbiter, included by the package and by RTL that needs them

`ifndef BUS_ARB_SETTINGS_SVH
`define BUS_ARB_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////////////////////////

// Width of one operand beat on the shared bus
`define BUS_ARB_ELEN 64

// Width of the operation code issued by the sequencer
`define BUS_ARB_OP_WIDTH 6

//////////////////////////////////////////////////////////////////////
// Ordering
//////////////////////////////////////////////////////////////////////

// One entry per instruction ID that can be in flight
`define BUS_ARB_ORDER_DEPTH 8

`endif
